// ==== hw/fb_geom_pkg.sv ====
package fb_geom_pkg;

  // raster size of the panel
  localparam int disp_width  = 16;
  localparam int disp_height = 12;

  // pixels held by one buffer
  localparam int fb_depth = disp_width * disp_height;

  // one byte per pixel
  localparam int color_bits = 8;

  // linear pixel address, y * disp_width + x
  localparam int addr_bits = $clog2(fb_depth);

  // address-to-data delay of tdp_ram
  localparam int ram_latency = 2;

endpackage

// ==== hw/fb_draw_pkg.sv ====
package fb_draw_pkg;

  // column coordinate, covers 0 .. disp_width-1
  localparam int x_bits = 4;

  // row coordinate, covers 0 .. disp_height-1 with spare codes above
  localparam int y_bits = 4;

  // rectangle extents are one bit wider than the coordinates
  // so that a full row or column can be requested

endpackage

// ==== hw/tdp_ram.sv ====
`timescale 1ns/10ps

module tdp_ram #(
  parameter int ram_width = fb_geom_pkg::color_bits,
  parameter int ram_depth = fb_geom_pkg::fb_depth
) (
  input  logic                         clk,
  input  logic                         we,
  input  logic [$clog2(ram_depth)-1:0] waddr,
  input  logic [ram_width-1:0]         wdata,
  input  logic [$clog2(ram_depth)-1:0] raddr,
  output logic [ram_width-1:0]         rdata
);

  logic [ram_width-1:0] mem [ram_depth];
  logic [ram_width-1:0] mem_q; // first read stage

  // write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // read port, old contents are returned when both ports hit one word
  always_ff @(posedge clk) begin
    mem_q <= mem[raddr];
    rdata <= mem_q; // output register, second cycle
  end

endmodule

// ==== hw/bram_manager.sv ====
`timescale 1ns/10ps

module bram_manager (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                swap,
  input  logic                                we,
  input  logic [fb_geom_pkg::addr_bits-1:0]   waddr,
  input  logic [fb_geom_pkg::color_bits-1:0]  wdata,
  input  logic [fb_geom_pkg::addr_bits-1:0]   read_addr,
  output logic [fb_geom_pkg::color_bits-1:0]  read_data,
  output logic                                front_buffer
);

  logic back_next;  // back buffer for the write in this cycle
  logic back_sel;   // registered back buffer select
  logic back_sel_d; // same select, one more cycle behind

  logic [fb_geom_pkg::color_bits-1:0] ram_rdata [2];

  assign back_next = swap ? !back_sel : back_sel;

  // the select trails the swap by the read latency so a scan in flight
  // keeps reading from one buffer
  always_ff @(posedge clk) begin
    if (rst) begin
      back_sel   <= 1'b0;
      back_sel_d <= 1'b0;
    end else begin
      back_sel   <= back_next;
      back_sel_d <= back_sel;
    end
  end

  assign front_buffer = !back_sel_d;

  for (genvar i = 0; i < 2; i++) begin : g_buf
    tdp_ram #(
      .ram_width(fb_geom_pkg::color_bits),
      .ram_depth(fb_geom_pkg::fb_depth)
    ) ram_inst (
      .clk  (clk),
      .we   (we && (back_next == i[0])), // only the back buffer takes writes
      .waddr(waddr),
      .wdata(wdata),
      .raddr(read_addr),
      .rdata(ram_rdata[i])
    );
  end

  assign read_data = front_buffer ? ram_rdata[1] : ram_rdata[0];

endmodule

// ==== hw/rect_filler.sv ====
`timescale 1ns/10ps

module rect_filler (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               start,
  input  logic [fb_draw_pkg::x_bits-1:0]     x0,
  input  logic [fb_draw_pkg::y_bits-1:0]     y0,
  input  logic [fb_draw_pkg::x_bits:0]       w,
  input  logic [fb_draw_pkg::y_bits:0]       h,
  input  logic [fb_geom_pkg::color_bits-1:0] color,
  input  logic                               grant,
  output logic                               req,
  output logic [fb_geom_pkg::addr_bits-1:0]  addr,
  output logic [fb_geom_pkg::color_bits-1:0] wcolor,
  output logic                               busy
);

  logic [fb_draw_pkg::x_bits+1:0] x_end; // last column before clipping
  logic [fb_draw_pkg::y_bits+1:0] y_end; // last row before clipping
  logic                           no_area;
  logic                           empty;
  logic [fb_draw_pkg::x_bits-1:0] x_first;
  logic [fb_draw_pkg::x_bits-1:0] x_last;
  logic [fb_draw_pkg::x_bits-1:0] cur_x;
  logic [fb_draw_pkg::y_bits-1:0] y_last;
  logic [fb_draw_pkg::y_bits-1:0] cur_y;
  logic                           row_end;
  logic                           last_pixel;

  assign x_end   = {2'b00, x0} + {1'b0, w} - 1'b1;
  assign y_end   = {2'b00, y0} + {1'b0, h} - 1'b1;
  assign no_area = (w == '0) || (h == '0) || (y0 >= fb_geom_pkg::disp_height);

  // command latch, taken only when idle
  always_ff @(posedge clk) begin
    if (start && !busy) begin
      x_first <= x0;
      x_last  <= (x_end > fb_geom_pkg::disp_width - 1) ?
                 fb_draw_pkg::x_bits'(fb_geom_pkg::disp_width - 1) :
                 x_end[fb_draw_pkg::x_bits-1:0];
      y_last  <= (y_end > fb_geom_pkg::disp_height - 1) ?
                 fb_draw_pkg::y_bits'(fb_geom_pkg::disp_height - 1) :
                 y_end[fb_draw_pkg::y_bits-1:0];
      wcolor  <= color;
    end
  end

  assign row_end    = (cur_x == x_last);
  assign last_pixel = row_end && (cur_y == y_last);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy  <= 1'b0;
      empty <= 1'b0;
      cur_x <= '0;
      cur_y <= '0;
    end else if (!busy) begin
      if (start) begin
        busy  <= 1'b1;
        empty <= no_area;
        cur_x <= x0;
        cur_y <= y0;
      end
    end else if (empty) begin
      busy <= 1'b0; // nothing to draw, one busy cycle only
    end else if (grant) begin
      if (last_pixel) begin
        busy <= 1'b0;
      end else if (row_end) begin
        cur_x <= x_first; // wrap to the next row
        cur_y <= cur_y + 1'b1;
      end else begin
        cur_x <= cur_x + 1'b1;
      end
    end
  end

  assign req  = busy && !empty;
  assign addr = fb_geom_pkg::addr_bits'(cur_y * fb_geom_pkg::disp_width + cur_x);

endmodule

// ==== hw/write_arbiter.sv ====
`timescale 1ns/10ps

module write_arbiter (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               host_we,
  input  logic [fb_draw_pkg::x_bits-1:0]     host_x,
  input  logic [fb_draw_pkg::y_bits-1:0]     host_y,
  input  logic [fb_geom_pkg::color_bits-1:0] host_color,
  input  logic                               fill_req,
  input  logic [fb_geom_pkg::addr_bits-1:0]  fill_addr,
  input  logic [fb_geom_pkg::color_bits-1:0] fill_color,
  output logic                               fill_grant,
  output logic                               we,
  output logic [fb_geom_pkg::addr_bits-1:0]  waddr,
  output logic [fb_geom_pkg::color_bits-1:0] wdata
);

  logic [fb_geom_pkg::addr_bits-1:0] host_addr;

  assign host_addr = fb_geom_pkg::addr_bits'(host_y * fb_geom_pkg::disp_width + host_x);

  // host strobes cannot wait, so the filler only gets the idle cycles
  assign fill_grant = fill_req && !host_we;

  always_ff @(posedge clk) begin
    if (rst) begin
      we <= 1'b0;
    end else begin
      we <= host_we || fill_grant;
    end
  end

  // payload follows the winner
  always_ff @(posedge clk) begin
    if (host_we) begin
      waddr <= host_addr;
      wdata <= host_color;
    end else begin
      waddr <= fill_addr;
      wdata <= fill_color;
    end
  end

endmodule

// ==== hw/scan_reader.sv ====
`timescale 1ns/10ps

module scan_reader (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               frame_start,
  output logic [fb_geom_pkg::addr_bits-1:0]  read_addr,
  input  logic [fb_geom_pkg::color_bits-1:0] read_data,
  output logic                               pixel_valid,
  output logic [fb_geom_pkg::color_bits-1:0] pixel_data,
  output logic                               frame_done
);

  logic                              active;   // an address goes out this cycle
  logic [fb_geom_pkg::addr_bits-1:0] addr_cnt;
  logic                              last_addr;
  logic [fb_geom_pkg::ram_latency-1:0] valid_pipe;
  logic [fb_geom_pkg::ram_latency-1:0] last_pipe;

  assign last_addr = (addr_cnt == fb_geom_pkg::addr_bits'(fb_geom_pkg::fb_depth - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      active   <= 1'b0;
      addr_cnt <= '0;
    end else if (!active) begin
      if (frame_start) begin
        active   <= 1'b1;
        addr_cnt <= '0;
      end
    end else begin
      addr_cnt <= addr_cnt + 1'b1;
      if (last_addr) begin
        active <= 1'b0;
      end
    end
  end

  assign read_addr = addr_cnt;

  // flags ride alongside the RAM read so several pixels are in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_pipe <= '0;
      last_pipe  <= '0;
    end else begin
      valid_pipe <= {valid_pipe[fb_geom_pkg::ram_latency-2:0], active};
      last_pipe  <= {last_pipe[fb_geom_pkg::ram_latency-2:0], active && last_addr};
    end
  end

  assign pixel_valid = valid_pipe[fb_geom_pkg::ram_latency-1];
  assign frame_done  = last_pipe[fb_geom_pkg::ram_latency-1];
  assign pixel_data  = read_data; // already aligned with pixel_valid

endmodule

// ==== hw/fb_top.sv ====
`timescale 1ns/10ps

module fb_top (
  input  logic                               clk,
  input  logic                               rst,
  // host pixel writes
  input  logic                               pix_we,
  input  logic [fb_draw_pkg::x_bits-1:0]     pix_x,
  input  logic [fb_draw_pkg::y_bits-1:0]     pix_y,
  input  logic [fb_geom_pkg::color_bits-1:0] pix_color,
  // rectangle fill
  input  logic                               fill_start,
  input  logic [fb_draw_pkg::x_bits-1:0]     fill_x,
  input  logic [fb_draw_pkg::y_bits-1:0]     fill_y,
  input  logic [fb_draw_pkg::x_bits:0]       fill_w,
  input  logic [fb_draw_pkg::y_bits:0]       fill_h,
  input  logic [fb_geom_pkg::color_bits-1:0] fill_color,
  output logic                               fill_busy,
  // buffers
  input  logic                               swap,
  // scan out
  input  logic                               frame_start,
  output logic                               pixel_valid,
  output logic [fb_geom_pkg::color_bits-1:0] pixel_data,
  output logic                               frame_done,
  output logic                               front_buffer
);

  logic                               fill_req;
  logic                               fill_grant;
  logic [fb_geom_pkg::addr_bits-1:0]  fill_addr;
  logic [fb_geom_pkg::color_bits-1:0] fill_wcolor;
  logic                               ram_we;
  logic [fb_geom_pkg::addr_bits-1:0]  ram_waddr;
  logic [fb_geom_pkg::color_bits-1:0] ram_wdata;
  logic [fb_geom_pkg::addr_bits-1:0]  read_addr;
  logic [fb_geom_pkg::color_bits-1:0] read_data;

  rect_filler rect_filler_inst (
    .clk   (clk),
    .rst   (rst),
    .start (fill_start),
    .x0    (fill_x),
    .y0    (fill_y),
    .w     (fill_w),
    .h     (fill_h),
    .color (fill_color),
    .grant (fill_grant),
    .req   (fill_req),
    .addr  (fill_addr),
    .wcolor(fill_wcolor),
    .busy  (fill_busy)
  );

  write_arbiter write_arbiter_inst (
    .clk       (clk),
    .rst       (rst),
    .host_we   (pix_we),
    .host_x    (pix_x),
    .host_y    (pix_y),
    .host_color(pix_color),
    .fill_req  (fill_req),
    .fill_addr (fill_addr),
    .fill_color(fill_wcolor),
    .fill_grant(fill_grant),
    .we        (ram_we),
    .waddr     (ram_waddr),
    .wdata     (ram_wdata)
  );

  bram_manager bram_manager_inst (
    .clk         (clk),
    .rst         (rst),
    .swap        (swap),
    .we          (ram_we),
    .waddr       (ram_waddr),
    .wdata       (ram_wdata),
    .read_addr   (read_addr),
    .read_data   (read_data),
    .front_buffer(front_buffer)
  );

  scan_reader scan_reader_inst (
    .clk        (clk),
    .rst        (rst),
    .frame_start(frame_start),
    .read_addr  (read_addr),
    .read_data  (read_data),
    .pixel_valid(pixel_valid),
    .pixel_data (pixel_data),
    .frame_done (frame_done)
  );

endmodule

// ==== bench/fb_tb.sv ====
`timescale 1ns/10ps

module fb_tb;

  localparam int npix   = fb_geom_pkg::fb_depth;
  localparam int width  = fb_geom_pkg::disp_width;
  localparam int height = fb_geom_pkg::disp_height;
  localparam int xw     = fb_draw_pkg::x_bits;
  localparam int yw     = fb_draw_pkg::y_bits;
  localparam int cw     = fb_geom_pkg::color_bits;

  // frame_done lands in the 195th cycle when frame_start is counted as cycle 0
  localparam int done_delay = npix + 2;

  logic          clk = 1'b0;
  logic          rst;
  logic          pix_we;
  logic [xw-1:0] pix_x;
  logic [yw-1:0] pix_y;
  logic [cw-1:0] pix_color;
  logic          fill_start;
  logic [xw-1:0] fill_x;
  logic [yw-1:0] fill_y;
  logic [xw:0]   fill_w;
  logic [yw:0]   fill_h;
  logic [cw-1:0] fill_color;
  logic          fill_busy;
  logic          swap;
  logic          frame_start;
  logic          pixel_valid;
  logic [cw-1:0] pixel_data;
  logic          frame_done;
  logic          front_buffer;

  logic [cw-1:0] model_mem [2][npix]; // both buffers as the DUT should hold them
  logic          m_back;              // back buffer named by the current cycle
  logic          back_d1;
  logic          back_d2;             // select as seen two cycles later
  logic          m_busy;
  logic          m_empty;
  int            m_x;
  int            m_y;
  int            m_x0;
  int            m_xl;
  int            m_yl;
  logic [cw-1:0] m_color;
  logic          scan_on;
  logic          scan_seen;
  int            scan_idx;
  int            scan_cycles;
  logic [31:0]   scan_sum;
  int            frame_no;
  byte           cmd_op;
  int            cmd_arg [5];
  int            error_count = 0;
  int            cycle_count = 0;
  int            cycle_limit = 1000000;

  fb_top fb_top_inst (
    .clk(clk), .rst(rst),
    .pix_we(pix_we), .pix_x(pix_x), .pix_y(pix_y), .pix_color(pix_color),
    .fill_start(fill_start), .fill_x(fill_x), .fill_y(fill_y), .fill_w(fill_w),
    .fill_h(fill_h), .fill_color(fill_color), .fill_busy(fill_busy),
    .swap(swap),
    .frame_start(frame_start), .pixel_valid(pixel_valid), .pixel_data(pixel_data),
    .frame_done(frame_done), .front_buffer(front_buffer)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      abort_run("timeout, the commands did not finish within the cycle limit");
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  // checks this cycle's outputs, updates the model, then moves to the next cycle
  task automatic run_cycle();
    logic next_back;
    logic next_busy;
    int   x_end;
    int   y_end;
    check_value("front buffer select", 32'(!back_d2), 32'(front_buffer));
    check_value("fill busy", 32'(m_busy), 32'(fill_busy));
    if (scan_on && scan_seen) begin
      check_value("pixel valid inside the frame", 1, 32'(pixel_valid));
    end
    if (!scan_on) begin
      check_value("pixel valid outside a frame", 0, 32'(pixel_valid));
      check_value("frame done outside a frame", 0, 32'(frame_done));
    end
    if (scan_on && pixel_valid) begin
      check_value("pixel index below frame size", 1, 32'(scan_idx < npix));
      check_value($sformatf("frame %0d pixel %0d", frame_no, scan_idx),
                  32'(model_mem[!back_d2][scan_idx]), 32'(pixel_data));
      scan_sum = scan_sum + 32'(pixel_data);
      scan_idx++;
      scan_seen = 1'b1;
    end
    if (scan_on && frame_done) begin
      check_value("frame done on a valid pixel", 1, 32'(pixel_valid));
      check_value($sformatf("frame %0d pixel count", frame_no), npix, scan_idx);
      check_value($sformatf("frame %0d done cycle", frame_no), done_delay, scan_cycles);
      scan_on = 1'b0;
    end
    if (scan_on) begin
      scan_cycles++;
    end

    next_busy = m_busy;
    if (pix_we) begin
      model_mem[m_back][int'(pix_y) * width + int'(pix_x)] = pix_color; // host always wins
    end
    if (!m_busy) begin
      if (fill_start) begin
        next_busy = 1'b1;
        m_empty   = (int'(fill_w) == 0) || (int'(fill_h) == 0) || (int'(fill_y) >= height);
        m_x0      = int'(fill_x);
        m_x       = m_x0;
        m_y       = int'(fill_y);
        x_end     = m_x0 + int'(fill_w) - 1;
        y_end     = m_y + int'(fill_h) - 1;
        m_xl      = (x_end > width - 1) ? width - 1 : x_end;   // clip at the right edge
        m_yl      = (y_end > height - 1) ? height - 1 : y_end; // and at the bottom
        m_color   = fill_color;
      end
    end else if (m_empty) begin
      next_busy = 1'b0;
    end else if (!pix_we) begin
      model_mem[m_back][m_y * width + m_x] = m_color;
      if (m_x == m_xl && m_y == m_yl) begin
        next_busy = 1'b0;
      end else if (m_x == m_xl) begin
        m_x = m_x0;
        m_y++;
      end else begin
        m_x++;
      end
    end
    m_busy = next_busy;

    next_back = swap ? !m_back : m_back;
    back_d2   = back_d1;
    back_d1   = next_back;
    m_back    = next_back;

    @(posedge clk);
    #1;
    pix_we      = 1'b0;
    fill_start  = 1'b0;
    swap        = 1'b0;
    frame_start = 1'b0;
  endtask

  // reads one command into cmd_op and cmd_arg and skips lines that start with #
  task automatic read_command(input int fd, output bit got);
    int c;
    int n;
    int code;
    bit more;
    got  = 1'b0;
    more = 1'b1;
    n    = 0;
    while (more) begin
      c = $fgetc(fd);
      while (c == 32 || c == 9 || c == 10 || c == 13) begin
        c = $fgetc(fd);
      end
      cmd_op = byte'(c);
      if (c == -1) begin
        more = 1'b0;
      end else if (cmd_op == "#") begin
        while (c != 10 && c != -1) begin
          c = $fgetc(fd);
        end
      end else begin
        case (cmd_op)
          "P":      n = 3;
          "R":      n = 5;
          "W", "F": n = 1;
          "S":      n = 0;
          default:  abort_run($sformatf("unknown command %c in the test data", cmd_op));
        endcase
        for (int i = 0; i < n; i++) begin
          code = $fscanf(fd, " %h", cmd_arg[i]);
          if (code != 1) begin
            abort_run("malformed command line in the test data");
          end
        end
        got  = 1'b1;
        more = 1'b0;
      end
    end
  endtask

  initial begin
    int fd;
    bit got;
    int limit;
    rst = 1'b1;
    pix_we = 1'b0;
    pix_x = '0;
    pix_y = '0;
    pix_color = '0;
    fill_start = 1'b0;
    fill_x = '0;
    fill_y = '0;
    fill_w = '0;
    fill_h = '0;
    fill_color = '0;
    swap = 1'b0;
    frame_start = 1'b0;
    m_back = 1'b0;
    back_d1 = 1'b0;
    back_d2 = 1'b0;
    m_busy = 1'b0;
    m_empty = 1'b0;
    scan_on = 1'b0;
    scan_seen = 1'b0;
    scan_cycles = 0;
    frame_no = 0;

    // first pass sizes the timeout
    fd = $fopen("bench/fb_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open bench/fb_testdata.txt");
    end
    limit = 16 + 100;
    got = 1'b1;
    while (got) begin
      read_command(fd, got);
      if (got) begin
        case (cmd_op)
          "P": limit += 1;
          "R": limit += cmd_arg[2] * cmd_arg[3] + 3;
          "S": limit += 2;
          "W": limit += cmd_arg[0];
          "F": limit += 200;
          default: limit += 1;
        endcase
      end
    end
    $fclose(fd);
    cycle_limit = limit;

    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    fd = $fopen("bench/fb_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("cannot reopen bench/fb_testdata.txt");
    end
    got = 1'b1;
    while (got) begin
      read_command(fd, got);
      if (got) begin
        case (cmd_op)
          "P": begin
            pix_x     = xw'(cmd_arg[0]);
            pix_y     = yw'(cmd_arg[1]);
            pix_color = cw'(cmd_arg[2]);
            pix_we    = 1'b1;
            run_cycle();
          end
          "R": begin
            while (fill_busy) run_cycle();
            fill_x     = xw'(cmd_arg[0]);
            fill_y     = yw'(cmd_arg[1]);
            fill_w     = (xw + 1)'(cmd_arg[2]);
            fill_h     = (yw + 1)'(cmd_arg[3]);
            fill_color = cw'(cmd_arg[4]);
            fill_start = 1'b1;
            run_cycle();
          end
          "S": begin
            while (fill_busy) run_cycle();
            run_cycle(); // lets the last registered write land first
            swap = 1'b1;
            run_cycle();
          end
          "W": repeat (cmd_arg[0]) run_cycle();
          "F": begin
            frame_no++;
            scan_on     = 1'b1;
            scan_seen   = 1'b0;
            scan_idx    = 0;
            scan_cycles = 0;
            scan_sum    = '0;
            frame_start = 1'b1;
            run_cycle();
            while (scan_on) run_cycle();
            check_value($sformatf("frame %0d checksum", frame_no), cmd_arg[0], scan_sum);
          end
          default: run_cycle();
        endcase
      end
    end
    $fclose(fd);
    repeat (4) run_cycle();

    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== bench/fb_testdata.txt ====
# one command per line, all numbers hex
# P x y colour | R x y w h colour | S | W cycles | F checksum (32-bit sum of the frame)
#
# fill both buffers, buffer 0 first since it starts as the back buffer
R 0 0 10 c 10
S
F c00
R 0 0 10 c 20
# host writes racing the fill, the one to pixel 5 lands after the fill passed it
P 3 2 ff
W a
P 5 0 aa
P 0 b bb
# front buffer is untouched until the swap
F c00
S
F 188a
# clipped and empty rectangles into buffer 0
R c 9 8 5 05
R 2 3 0 4 77
R 1 1 3 2 40
R 3 d 2 2 99
R 4 4 3 0 66
S
F c9c
# two rows of fill in buffer 1 with host writes interleaved
R 0 0 10 2 c0
W 3
P 1 0 01
P 3 0 02
P 8 5 03
W 2
P 4 0 04
S
F 2a68
# write the back buffer, the front scan stays the same
P f b e0
F 2a68
S
F d77

// ==== flist.f ====
hw/fb_geom_pkg.sv
hw/fb_draw_pkg.sv
hw/tdp_ram.sv
hw/bram_manager.sv
hw/rect_filler.sv
hw/write_arbiter.sv
hw/scan_reader.sv
hw/fb_top.sv
bench/fb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the frame buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module fb_tb -f flist.f -o fb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/fb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi
